//--- rtl/decode_issue.sv
// instruction queue and issue logic for decode
// holds fetched instructions, tracks execute credits, returns fetch credits
// and registers the decoded bundle towards execute
`timescale 1ns/1ns

module decode_issue
	import pipe_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        flush,
	input  logic        instr_valid,
	input  logic [31:0] instr,
	input  logic [31:0] pc_next,
	input  logic        exec_credit,
	input  logic [31:0] rs1_data,
	input  logic [31:0] rs2_data,
	input  logic [31:0] imm,
	input  alu_src_t    alu_src,
	input  logic [4:0]  alu_op,
	input  logic        branch,
	input  logic        jump,
	input  logic        mem_wrt,
	input  logic        mem_en,
	input  result_sel_t result_sel,
	input  logic        next_reg_wrt_en,
	input  logic [4:0]  next_reg_wrt_sel,
	input  logic        lr_read,
	input  logic        lr_write,
	input  logic        fl_read,
	input  logic        fl_write,
	output logic [31:0] head_instr,
	output logic        fetch_credit,
	output logic        out_valid,
	output logic [31:0] ex_pc_next,
	output logic [31:0] ex_rs1_data,
	output logic [31:0] ex_rs2_data,
	output logic [31:0] ex_imm,
	output alu_src_t    ex_alu_src,
	output logic [4:0]  ex_alu_op,
	output logic        ex_branch,
	output logic        ex_jump,
	output logic        ex_mem_wrt,
	output logic        ex_mem_en,
	output result_sel_t ex_result_sel,
	output logic        ex_reg_wrt_en,
	output logic [4:0]  ex_reg_wrt_sel,
	output logic        ex_lr_read,
	output logic        ex_lr_write,
	output logic        ex_fl_read,
	output logic        ex_fl_write
);

	logic [31:0]         q_instr [IQ_DEPTH];
	logic [31:0]         q_pc [IQ_DEPTH];
	logic [IQ_PTR_W-1:0] wr_ptr;
	logic [IQ_PTR_W-1:0] rd_ptr;
	logic [IQ_CNT_W-1:0] count;
	logic [CREDIT_W-1:0] credit_cnt;
	logic                push;
	logic                issue;

	function automatic logic [IQ_PTR_W-1:0] ptr_inc(input logic [IQ_PTR_W-1:0] ptr);
		return (ptr == IQ_PTR_W'(IQ_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign head_instr = q_instr[rd_ptr];

	// flush drops both the incoming and the issuing instruction
	assign push = instr_valid && !flush;
	assign issue = (count != '0) && (credit_cnt != '0) && !flush;

	always_ff @(posedge clk) begin
		if (push) begin
			q_instr[wr_ptr] <= instr;
			q_pc[wr_ptr] <= pc_next;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else if (flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (issue)
				rd_ptr <= ptr_inc(rd_ptr);
			count <= count + IQ_CNT_W'(push) - IQ_CNT_W'(issue);
		end
	end

	// execute credits, a return and an issue in one cycle cancel out
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			credit_cnt <= CREDIT_W'(EXEC_CREDITS);
		end else begin
			case ({exec_credit, issue})
				2'b10: credit_cnt <= credit_cnt + 1'b1;
				2'b01: credit_cnt <= credit_cnt - 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			fetch_credit <= 1'b0;
		end else begin
			out_valid <= issue;
			// freed queue slot goes back to fetch
			fetch_credit <= issue;
		end
	end

	// bundle payload, qualified by out_valid
	always_ff @(posedge clk) begin
		if (issue) begin
			ex_pc_next <= q_pc[rd_ptr];
			ex_rs1_data <= rs1_data;
			ex_rs2_data <= rs2_data;
			ex_imm <= imm;
			ex_alu_src <= alu_src;
			ex_alu_op <= alu_op;
			ex_branch <= branch;
			ex_jump <= jump;
			ex_mem_wrt <= mem_wrt;
			ex_mem_en <= mem_en;
			ex_result_sel <= result_sel;
			ex_reg_wrt_en <= next_reg_wrt_en;
			ex_reg_wrt_sel <= next_reg_wrt_sel;
			ex_lr_read <= lr_read;
			ex_lr_write <= lr_write;
			ex_fl_read <= fl_read;
			ex_fl_write <= fl_write;
		end
	end

endmodule

//--- rtl/decode_stage.sv
// decode stage top level
// queue and issue, decoder, register file and LR/FL
`timescale 1ns/1ns

module decode_stage
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input  logic             clk,
	input  logic             rst_n,
	input  logic             flush,
	// fetch side
	input  logic             instr_valid,
	input  logic [XLEN-1:0]  instr,
	input  logic [XLEN-1:0]  pc_next,
	output logic             fetch_credit,
	// execute side
	input  logic             exec_credit,
	output logic             out_valid,
	output logic [XLEN-1:0]  ex_pc_next,
	output logic [XLEN-1:0]  ex_rs1_data,
	output logic [XLEN-1:0]  ex_rs2_data,
	output logic [XLEN-1:0]  ex_imm,
	output alu_src_t         ex_alu_src,
	output logic [OPC_W-1:0] ex_alu_op,
	output logic             ex_branch,
	output logic             ex_jump,
	output logic             ex_mem_wrt,
	output logic             ex_mem_en,
	output result_sel_t      ex_result_sel,
	output logic             ex_reg_wrt_en,
	output reg_idx_t         ex_reg_wrt_sel,
	output logic             ex_lr_read,
	output logic             ex_lr_write,
	output logic             ex_fl_read,
	output logic             ex_fl_write,
	// writeback side
	input  logic             reg_wrt_en,
	input  reg_idx_t         reg_wrt_sel,
	input  logic [XLEN-1:0]  reg_wrt_data,
	input  logic             lr_write_in,
	input  logic [XLEN-1:0]  lr_wrt_data,
	input  logic             fl_write_in,
	input  logic [FL_W-1:0]  fl_wrt_data
);

	logic [XLEN-1:0]  head_instr;
	logic [XLEN-1:0]  imm;
	alu_src_t         alu_src;
	logic [OPC_W-1:0] alu_op;
	logic             branch;
	logic             jump;
	logic             mem_wrt;
	logic             mem_en;
	result_sel_t      result_sel;
	logic             next_reg_wrt_en;
	reg_idx_t         next_reg_wrt_sel;
	logic             lr_read;
	logic             lr_write;
	logic             fl_read;
	logic             fl_write;
	logic [XLEN-1:0]  rs1_data;
	logic [XLEN-1:0]  rs2_data;
	logic [XLEN-1:0]  lr;
	logic [FL_W-1:0]  fl;

	decode_issue i_issue (.*);

	// decoder and register reads both work on the queue head
	instr_decoder i_decoder (
		.instr(head_instr),
		.*
	);

	reg_file i_reg_file (
		.rs1(head_instr[RS1_MSB:RS1_LSB]),
		.rs2(head_instr[RS2_MSB:RS2_LSB]),
		.*
	);

	special_regs i_special_regs (.*);

endmodule

//--- rtl/instr_decoder.sv
// instruction decoder
// turns one instruction into execute, memory and writeback controls
// plus the immediate and the LR/FL access flags
`timescale 1ns/1ns

module instr_decoder
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input  logic [XLEN-1:0]  instr,
	output logic [XLEN-1:0]  imm,
	output alu_src_t         alu_src,
	output logic [OPC_W-1:0] alu_op,
	output logic             branch,
	output logic             jump,
	output logic             mem_wrt,
	output logic             mem_en,
	output result_sel_t      result_sel,
	output logic             next_reg_wrt_en,
	output reg_idx_t         next_reg_wrt_sel,
	output logic             lr_read,
	output logic             lr_write,
	output logic             fl_read,
	output logic             fl_write
);

	opcode_t  opc;
	reg_idx_t rd;
	reg_idx_t rs1;
	reg_idx_t rs2;
	logic     lr_rs1;
	logic     fl_rs1;
	logic     lr_rs2;
	logic     fl_rs2;

	assign opc = opcode_t'(instr[OPC_MSB:OPC_LSB]);
	assign rd = instr[RD_MSB:RD_LSB];
	assign rs1 = instr[RS1_MSB:RS1_LSB];
	assign rs2 = instr[RS2_MSB:RS2_LSB];

	// special register reads by source field
	assign lr_rs1 = (rs1 == REG_LR);
	assign fl_rs1 = (rs1 == REG_FL);
	assign lr_rs2 = (rs2 == REG_LR);
	assign fl_rs2 = (rs2 == REG_FL);

	always_comb begin
		imm = '0;
		alu_src = SRC_REG;
		alu_op = instr[OPC_MSB:OPC_LSB];
		branch = 1'b0;
		jump = 1'b0;
		mem_wrt = 1'b0;
		mem_en = 1'b0;
		result_sel = RES_ALU;
		next_reg_wrt_en = 1'b0;
		next_reg_wrt_sel = '0;
		lr_read = 1'b0;
		lr_write = 1'b0;
		fl_read = 1'b0;
		fl_write = 1'b0;

		case (opc)
			OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SLR, OP_SAR: begin
				next_reg_wrt_en = 1'b1;
				next_reg_wrt_sel = rd;
				lr_read = lr_rs1 | lr_rs2;
				fl_read = fl_rs1 | fl_rs2;
			end
			OP_ADDI, OP_SUBI: begin
				alu_src = SRC_IMM;
				imm = {{(XLEN-IMM12_W){instr[IMM12_W-1]}}, instr[IMM12_W-1:0]};
				next_reg_wrt_en = 1'b1;
				next_reg_wrt_sel = rd;
				lr_read = lr_rs1;
				fl_read = fl_rs1;
			end
			OP_NEG: begin
				next_reg_wrt_en = 1'b1;
				next_reg_wrt_sel = rd;
				lr_read = lr_rs1;
				fl_read = fl_rs1;
			end
			OP_LD, OP_LDI: begin
				mem_en = 1'b1;
				result_sel = RES_MEM;
				next_reg_wrt_en = 1'b1;
				next_reg_wrt_sel = rd;
				if (opc == OP_LDI) begin
					alu_src = SRC_IMM;
					imm = {{(XLEN-IMM16_W){1'b0}}, instr[IMM16_W-1:0]};
				end else begin
					lr_read = lr_rs1;
					fl_read = fl_rs1;
				end
			end
			OP_ST, OP_STI: begin
				mem_en = 1'b1;
				mem_wrt = 1'b1;
				if (opc == OP_STI) begin
					alu_src = SRC_IMM;
					imm = {{(XLEN-IMM16_W){1'b0}}, instr[IMM16_W-1:0]};
				end else begin
					lr_read = lr_rs1;
					fl_read = fl_rs1;
				end
			end
			OP_BEQ, OP_BNE, OP_BON, OP_BNN: begin
				branch = 1'b1;
				result_sel = RES_PC;
				lr_read = lr_rs1;
				// condition always comes from the flags
				fl_read = 1'b1;
			end
			OP_J, OP_JAL: begin
				// word target, byte addressed memory
				alu_src = SRC_IMM;
				imm = {IMEM_BASE, instr[TGT_W-1:0], 2'b00};
				jump = 1'b1;
				result_sel = RES_PC;
				lr_write = (opc == OP_JAL);
			end
			OP_JR: begin
				jump = 1'b1;
				result_sel = RES_PC;
				lr_read = lr_rs1;
				fl_read = fl_rs1;
			end
			OP_NOP, OP_RIN: begin
			end
			default: begin
				// illegal opcode, everything high
				imm = '1;
				alu_src = SRC_ERR;
				alu_op = '1;
				branch = 1'b1;
				jump = 1'b1;
				mem_wrt = 1'b1;
				mem_en = 1'b1;
				result_sel = RES_ERR;
				next_reg_wrt_en = 1'b1;
				next_reg_wrt_sel = '1;
				lr_read = 1'b1;
				lr_write = 1'b1;
				fl_read = 1'b1;
				fl_write = 1'b1;
			end
		endcase
	end

endmodule

//--- rtl/isa_pkg.sv
// instruction set definitions for the 32-bit core
// opcodes, field positions, special register indices and immediates
package isa_pkg;

	localparam int XLEN = 32;
	localparam int OPC_W = 5;
	localparam int FL_W = 2;

	// RIN sits at the top of the space, 23..30 are illegal
	typedef enum logic [OPC_W-1:0] {
		OP_ADD  = 5'd0,
		OP_ADDI = 5'd1,
		OP_SUB  = 5'd2,
		OP_SUBI = 5'd3,
		OP_AND  = 5'd4,
		OP_OR   = 5'd5,
		OP_XOR  = 5'd6,
		OP_NEG  = 5'd7,
		OP_SLL  = 5'd8,
		OP_SLR  = 5'd9,
		OP_SAR  = 5'd10,
		OP_LD   = 5'd11,
		OP_LDI  = 5'd12,
		OP_ST   = 5'd13,
		OP_STI  = 5'd14,
		OP_NOP  = 5'd15,
		OP_BEQ  = 5'd16,
		OP_BNE  = 5'd17,
		OP_BON  = 5'd18,
		OP_BNN  = 5'd19,
		OP_J    = 5'd20,
		OP_JR   = 5'd21,
		OP_JAL  = 5'd22,
		OP_RIN  = 5'd31
	} opcode_t;

	typedef logic [4:0] reg_idx_t;

	// instruction fields
	localparam int OPC_MSB = 31;
	localparam int OPC_LSB = 27;
	localparam int RD_MSB = 26;
	localparam int RD_LSB = 22;
	localparam int RS1_MSB = 21;
	localparam int RS1_LSB = 17;
	localparam int RS2_MSB = 16;
	localparam int RS2_LSB = 12;
	// immediates and jump target start at bit 0
	localparam int IMM12_W = 12;
	localparam int IMM16_W = 16;
	localparam int TGT_W = 14;

	localparam reg_idx_t REG_ZERO = 5'd0;
	localparam reg_idx_t REG_LR = 5'd30;
	localparam reg_idx_t REG_FL = 5'd31;
	localparam int GPR_LAST = 29;

	// start of instruction memory, prefixed to jump targets
	localparam logic [15:0] IMEM_BASE = 16'h1000;

endpackage

//--- rtl/pipe_pkg.sv
// pipeline encodings shared by decode and its neighbours
// operand source, result select and credit depths
package pipe_pkg;

	typedef enum logic [1:0] {
		SRC_IMM = 2'd0,
		SRC_REG = 2'd1,
		SRC_ERR = 2'd3
	} alu_src_t;

	typedef enum logic [1:0] {
		RES_ALU = 2'd0,
		RES_MEM = 2'd1,
		RES_PC  = 2'd2,
		RES_ERR = 2'd3
	} result_sel_t;

	// instruction queue, also fetch's credits after reset
	localparam int IQ_DEPTH = 2;
	localparam int IQ_PTR_W = $clog2(IQ_DEPTH);
	localparam int IQ_CNT_W = $clog2(IQ_DEPTH + 1);

	// execute input slots
	localparam int EXEC_CREDITS = 4;
	localparam int CREDIT_W = 3;

endpackage

//--- rtl/reg_file.sv
// register file with two read ports and one write port
// r0 reads zero, r30/r31 map onto LR and FL, writeback bypassed to reads
`timescale 1ns/1ns

module reg_file
	import isa_pkg::*;
(
	input  logic            clk,
	input  logic            rst_n,
	input  reg_idx_t        rs1,
	input  reg_idx_t        rs2,
	input  logic            reg_wrt_en,
	input  reg_idx_t        reg_wrt_sel,
	input  logic [XLEN-1:0] reg_wrt_data,
	input  logic [XLEN-1:0] lr,
	input  logic [FL_W-1:0] fl,
	output logic [XLEN-1:0] rs1_data,
	output logic [XLEN-1:0] rs2_data
);

	logic [XLEN-1:0] regs [1:GPR_LAST];
	logic            wrt_ok;

	// r0, LR and FL are not writable from writeback
	assign wrt_ok = reg_wrt_en && (reg_wrt_sel != REG_ZERO) &&
		(reg_wrt_sel != REG_LR) && (reg_wrt_sel != REG_FL);

	function automatic logic [XLEN-1:0] read_port(input reg_idx_t idx);
		if (idx == REG_ZERO)
			return '0;
		if (idx == REG_LR)
			return lr;
		if (idx == REG_FL)
			return {{(XLEN-FL_W){1'b0}}, fl};
		// same-cycle writeback wins
		if (wrt_ok && (idx == reg_wrt_sel))
			return reg_wrt_data;
		return regs[idx];
	endfunction

	// reads follow the array, LR/FL and the writeback as well as the indices
	always_comb begin
		rs1_data = read_port(rs1);
		rs2_data = read_port(rs2);
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 1; i <= GPR_LAST; i++)
				regs[i] <= '0;
		end else if (wrt_ok) begin
			regs[reg_wrt_sel] <= reg_wrt_data;
		end
	end

endmodule

//--- rtl/special_regs.sv
// link register and flag register
// loaded from the later stages
`timescale 1ns/1ns

module special_regs
	import isa_pkg::*;
(
	input  logic            clk,
	input  logic            rst_n,
	input  logic            lr_write_in,
	input  logic [XLEN-1:0] lr_wrt_data,
	input  logic            fl_write_in,
	input  logic [FL_W-1:0] fl_wrt_data,
	output logic [XLEN-1:0] lr,
	output logic [FL_W-1:0] fl
);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			lr <= '0;
			fl <= '0;
		end else begin
			if (lr_write_in)
				lr <= lr_wrt_data;
			// flags come from execute
			if (fl_write_in)
				fl <= fl_wrt_data;
		end
	end

endmodule

//--- run.sh
#!/bin/sh
# compile and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module decode_tb \
	-f vlog.f -Mdir obj_dir -o decode_sim
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

./obj_dir/decode_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "All tests passed" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1

//--- verif/decode_ref.svh
// reference model for the decode stage testbench
// xorshift generator, expected decode of one instruction and register model
`ifndef DECODE_REF_SVH
`define DECODE_REF_SVH

// field order matches the concatenation used when sampling the DUT
typedef struct packed {
	alu_src_t         alu_src;
	logic [OPC_W-1:0] alu_op;
	logic             branch;
	logic             jump;
	logic             mem_wrt;
	logic             mem_en;
	result_sel_t      result_sel;
	logic             reg_wrt_en;
	reg_idx_t         reg_wrt_sel;
	logic             lr_read;
	logic             lr_write;
	logic             fl_read;
	logic             fl_write;
} ctrl_t;

typedef struct packed {
	ctrl_t           ctrl;
	logic [XLEN-1:0] imm;
} ref_t;

// one instruction accepted by decode
typedef struct packed {
	logic [XLEN-1:0] instr;
	logic [XLEN-1:0] pc;
	logic [31:0]     id;
} sent_t;

logic [31:0] rng_state = 32'd90;

// register model, lr_seen/fl_seen hold the values of the cycle just ended
logic [XLEN-1:0] gpr_m [32];
logic [XLEN-1:0] lr_m;
logic [FL_W-1:0] fl_m;
logic [XLEN-1:0] lr_seen;
logic [FL_W-1:0] fl_seen;

function automatic logic [31:0] xorshift32();
	logic [31:0] x;
	x = rng_state;
	x ^= x << 13;
	x ^= x >> 17;
	x ^= x << 5;
	rng_state = x;
	return x;
endfunction

function automatic ref_t ref_decode(input logic [XLEN-1:0] ins);
	ref_t             r;
	logic [OPC_W-1:0] op;
	reg_idx_t         s1;
	reg_idx_t         s2;
	logic             use1;
	logic             use2;
	op = ins[31:27];
	s1 = ins[21:17];
	s2 = ins[16:12];
	use1 = 1'b0;
	use2 = 1'b0;
	r = '0;
	r.ctrl.alu_src = SRC_REG;
	r.ctrl.alu_op = op;
	case (op)
		OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SLR, OP_SAR: begin
			r.ctrl.reg_wrt_en = 1'b1;
			use1 = 1'b1;
			use2 = 1'b1;
		end
		OP_ADDI, OP_SUBI: begin
			r.ctrl.reg_wrt_en = 1'b1;
			r.ctrl.alu_src = SRC_IMM;
			r.imm = {{20{ins[11]}}, ins[11:0]};
			use1 = 1'b1;
		end
		OP_NEG: begin
			r.ctrl.reg_wrt_en = 1'b1;
			use1 = 1'b1;
		end
		OP_LD, OP_LDI: begin
			r.ctrl.reg_wrt_en = 1'b1;
			r.ctrl.mem_en = 1'b1;
			r.ctrl.result_sel = RES_MEM;
			use1 = (op == OP_LD);
		end
		OP_ST, OP_STI: begin
			r.ctrl.mem_en = 1'b1;
			r.ctrl.mem_wrt = 1'b1;
			use1 = (op == OP_ST);
		end
		OP_BEQ, OP_BNE, OP_BON, OP_BNN: begin
			r.ctrl.branch = 1'b1;
			r.ctrl.result_sel = RES_PC;
			r.ctrl.fl_read = 1'b1;
			use1 = 1'b1;
		end
		OP_J, OP_JAL: begin
			r.ctrl.jump = 1'b1;
			r.ctrl.alu_src = SRC_IMM;
			r.ctrl.result_sel = RES_PC;
			r.ctrl.lr_write = (op == OP_JAL);
			r.imm = {IMEM_BASE, ins[13:0], 2'b00};
		end
		OP_JR: begin
			r.ctrl.jump = 1'b1;
			r.ctrl.result_sel = RES_PC;
			use1 = 1'b1;
		end
		OP_NOP, OP_RIN: ;
		default: begin
			r = '1;
			return r;
		end
	endcase
	// both immediate forms of load and store take imm16
	if (op == OP_LDI || op == OP_STI) begin
		r.ctrl.alu_src = SRC_IMM;
		r.imm = {16'h0000, ins[15:0]};
	end
	r.ctrl.reg_wrt_sel = r.ctrl.reg_wrt_en ? reg_idx_t'(ins[26:22]) : REG_ZERO;
	r.ctrl.lr_read = (use1 && (s1 == REG_LR)) || (use2 && (s2 == REG_LR));
	r.ctrl.fl_read = r.ctrl.fl_read || (use1 && (s1 == REG_FL)) ||
		(use2 && (s2 == REG_FL));
	return r;
endfunction

function automatic logic [XLEN-1:0] ref_operand(input reg_idx_t idx);
	if (idx == REG_LR)
		return lr_seen;
	if (idx == REG_FL)
		return {{(XLEN-FL_W){1'b0}}, fl_seen};
	// gpr_m[0] is never written
	return gpr_m[idx];
endfunction

task automatic model_clear();
	for (int i = 0; i < 32; i++)
		gpr_m[i] = '0;
	lr_m = '0;
	fl_m = '0;
	lr_seen = '0;
	fl_seen = '0;
endtask

// one clock edge of writeback
task automatic model_edge(input logic we, input reg_idx_t sel, input logic [XLEN-1:0] data,
	input logic lr_we, input logic [XLEN-1:0] lr_d, input logic fl_we, input logic [FL_W-1:0] fl_d);
	lr_seen = lr_m;
	fl_seen = fl_m;
	if (we && sel != REG_ZERO && sel != REG_LR && sel != REG_FL)
		gpr_m[sel] = data;
	if (lr_we)
		lr_m = lr_d;
	if (fl_we)
		fl_m = fl_d;
endtask

`endif

//--- verif/decode_tb.sv
// testbench for the decode stage
// fetch, execute and writeback models around the DUT, every bundle
// is checked against the reference decode and register model
`timescale 1ns/1ns

module decode_tb
	import isa_pkg::*;
	import pipe_pkg::*;
();

	localparam int N_TESTS = 400;
	localparam int DRIVE_DLY = 10;

	logic             clk;
	logic             rst_n;
	logic             flush;
	logic             instr_valid;
	logic [XLEN-1:0]  instr;
	logic [XLEN-1:0]  pc_next;
	logic             fetch_credit;
	logic             exec_credit;
	logic             out_valid;
	logic [XLEN-1:0]  ex_pc_next;
	logic [XLEN-1:0]  ex_rs1_data;
	logic [XLEN-1:0]  ex_rs2_data;
	logic [XLEN-1:0]  ex_imm;
	alu_src_t         ex_alu_src;
	logic [OPC_W-1:0] ex_alu_op;
	logic             ex_branch;
	logic             ex_jump;
	logic             ex_mem_wrt;
	logic             ex_mem_en;
	result_sel_t      ex_result_sel;
	logic             ex_reg_wrt_en;
	reg_idx_t         ex_reg_wrt_sel;
	logic             ex_lr_read;
	logic             ex_lr_write;
	logic             ex_fl_read;
	logic             ex_fl_write;
	logic             reg_wrt_en;
	reg_idx_t         reg_wrt_sel;
	logic [XLEN-1:0]  reg_wrt_data;
	logic             lr_write_in;
	logic [XLEN-1:0]  lr_wrt_data;
	logic             fl_write_in;
	logic [FL_W-1:0]  fl_wrt_data;

	int fetch_credits;
	int in_flight;
	int n_bundles;
	int n_pulses;
	int cur_id;

	`include "decode_ref.svh"

	// instructions accepted and not yet seen at the output
	sent_t exp_q[$];

	decode_stage i_dut (.*);

	task automatic fail_now(input string what);
		$display("%s", what);
		$display("Some tests failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_ctrl(input string name, input ctrl_t exp, input ctrl_t act);
		if (exp !== act)
			fail_now($sformatf("Fail %s expected %h actual %h", name, exp, act));
	endtask

	task automatic check_word(input string name, input logic [XLEN-1:0] exp,
		input logic [XLEN-1:0] act);
		if (exp !== act)
			fail_now($sformatf("Fail %s expected %h actual %h", name, exp, act));
	endtask

	task automatic check_credit(input string name, input logic [CREDIT_W-1:0] exp,
		input logic [CREDIT_W-1:0] act);
		if (exp !== act)
			fail_now($sformatf("Fail %s expected %0d actual %0d", name, exp, act));
	endtask

	task automatic idle_inputs();
		flush = 1'b0;
		instr_valid = 1'b0;
		exec_credit = 1'b0;
		reg_wrt_en = 1'b0;
		lr_write_in = 1'b0;
		fl_write_in = 1'b0;
	endtask

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial begin
		repeat (N_TESTS * 40) @(posedge clk);
		fail_now("timeout, decode did not drain all instructions");
	end

	// queue and register model follow the DUT edge by edge
	always @(posedge clk) begin
		sent_t s;
		if (rst_n) begin
			s.instr = instr;
			s.pc = pc_next;
			s.id = cur_id;
			if (flush)
				exp_q.delete();
			else if (instr_valid)
				exp_q.push_back(s);
			model_edge(reg_wrt_en, reg_wrt_sel, reg_wrt_data, lr_write_in, lr_wrt_data,
				fl_write_in, fl_wrt_data);
		end
	end

	always @(negedge clk) begin
		sent_t e;
		ref_t  r;
		ctrl_t act;
		if (rst_n && fetch_credit) begin
			n_pulses++;
			fetch_credits++;
		end
		if (rst_n && out_valid) begin
			n_bundles++;
			in_flight++;
			if (in_flight > EXEC_CREDITS)
				fail_now("more bundles outstanding than execute credits");
			else if (exp_q.size() == 0)
				fail_now("bundle issued with no instruction pending");
			else begin
				e = exp_q.pop_front();
				r = ref_decode(e.instr);
				act = {ex_alu_src, ex_alu_op, ex_branch, ex_jump, ex_mem_wrt, ex_mem_en,
					ex_result_sel, ex_reg_wrt_en, ex_reg_wrt_sel, ex_lr_read, ex_lr_write,
					ex_fl_read, ex_fl_write};
				check_ctrl($sformatf("instr %0d controls", e.id), r.ctrl, act);
				check_word($sformatf("instr %0d imm", e.id), r.imm, ex_imm);
				check_word($sformatf("instr %0d pc_next", e.id), e.pc, ex_pc_next);
				check_word($sformatf("instr %0d rs1_data", e.id),
					ref_operand(e.instr[RS1_MSB:RS1_LSB]), ex_rs1_data);
				check_word($sformatf("instr %0d rs2_data", e.id),
					ref_operand(e.instr[RS2_MSB:RS2_LSB]), ex_rs2_data);
			end
		end
	end

	initial begin
		int          sent;
		int          cyc;
		logic        hold;
		logic [31:0] r;
		logic [31:0] r2;
		rst_n = 1'b0;
		idle_inputs();
		instr = '0;
		pc_next = '0;
		reg_wrt_sel = '0;
		reg_wrt_data = '0;
		lr_wrt_data = '0;
		fl_wrt_data = '0;
		fetch_credits = IQ_DEPTH;
		in_flight = 0;
		n_bundles = 0;
		n_pulses = 0;
		cur_id = 0;
		sent = 0;
		cyc = 0;
		model_clear();
		repeat (2) @(posedge clk);
		#DRIVE_DLY;
		rst_n = 1'b1;
		if (out_valid !== 1'b0 || fetch_credit !== 1'b0)
			fail_now("out_valid or fetch_credit high after reset");
		do begin
			@(posedge clk);
			#DRIVE_DLY;
			// a flush at the last edge hands fetch a full set of credits
			if (flush)
				fetch_credits = IQ_DEPTH;
			idle_inputs();
			r = xorshift32();
			r2 = xorshift32();
			cyc++;
			// execute stalls for 20 cycles out of every 80
			hold = (cyc % 80) >= 60;
			if (!hold && in_flight > 0 && r[0]) begin
				exec_credit = 1'b1;
				in_flight--;
			end
			if (sent < N_TESTS && fetch_credits > 0 && r[2:1] != 2'b00) begin
				instr = xorshift32();
				// first pass walks the whole opcode space
				if (sent < 32)
					instr[OPC_MSB:OPC_LSB] = 5'(sent);
				if (instr[0])
					instr[RS1_MSB:RS1_LSB] = {4'hf, instr[1]};
				if (instr[2])
					instr[RS2_MSB:RS2_LSB] = {4'hf, instr[3]};
				pc_next = {IMEM_BASE, 16'(sent * 4)};
				cur_id = sent;
				instr_valid = 1'b1;
				fetch_credits--;
				sent++;
			end
			if (sent > 40 && r[9:5] == 5'd0)
				flush = 1'b1;
			if (r[12:11] != 2'b00) begin
				reg_wrt_en = 1'b1;
				// half the writes aim at a source of the newest instruction
				reg_wrt_sel = r[13] ? instr[RS1_MSB:RS1_LSB] : r2[4:0];
				reg_wrt_data = xorshift32();
			end
			if (r[16:14] == 3'd0) begin
				lr_write_in = 1'b1;
				lr_wrt_data = r2;
			end
			if (r[19:17] == 3'd0) begin
				fl_write_in = 1'b1;
				fl_wrt_data = r2[6:5];
			end
		end while (sent < N_TESTS || instr_valid || exp_q.size() != 0 || in_flight != 0);
		@(posedge clk);
		#DRIVE_DLY;
		if (flush)
			fetch_credits = IQ_DEPTH;
		idle_inputs();
		repeat (3) @(negedge clk);
		check_credit("fetch credits at end", CREDIT_W'(IQ_DEPTH), CREDIT_W'(fetch_credits));
		check_word("fetch credit pulses", n_bundles, n_pulses);
		$display("All tests passed");
		$finish;
	end

endmodule

//--- vlog.f
+incdir+verif
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/instr_decoder.sv
rtl/reg_file.sv
rtl/special_regs.sv
rtl/decode_issue.sv
rtl/decode_stage.sv
verif/decode_tb.sv
